// ==== sysmem_defs.svh ====
`ifndef SYSMEM_DEFS_SVH
`define SYSMEM_DEFS_SVH

// data path of the single memory port
`define SYSMEM_DATA_W 64
`define SYSMEM_BE_W 8

// word address, 256 words deep
`define SYSMEM_ADDR_W 8

// avalon burstcount field
`define SYSMEM_BURST_W 8

// cycles the port stays in reset after init_reset_n rises
`define SYSMEM_POR_CYCLES 16

// read accept to first readdatavalid
`define SYSMEM_READ_LATENCY 2

`endif

// ==== sysmem_pkg.sv ====
`default_nettype none

`include "sysmem_defs.svh"

package sysmem_pkg;

	// bus fields
	typedef logic [`SYSMEM_DATA_W-1:0] data_t;
	typedef logic [`SYSMEM_BE_W-1:0] byteen_t;
	typedef logic [`SYSMEM_ADDR_W-1:0] addr_t;
	typedef logic [`SYSMEM_BURST_W-1:0] burst_t;

	// wide enough to hold the full power-on count
	typedef logic [$clog2(`SYSMEM_POR_CYCLES + 1)-1:0] por_count_t;

	// safe terminator states
	typedef enum logic [2:0] {
		st_idle,
		st_write,
		st_read,
		st_flush,
		st_drain,
		st_hold
	} term_state_t;

endpackage

`default_nettype wire

// ==== avmm_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// avalon-mm burst link between terminator and memory
interface avmm_if;

	// command and write beat
	sysmem_pkg::addr_t address;
	sysmem_pkg::burst_t burstcount;
	logic read;
	logic write;
	sysmem_pkg::data_t writedata;
	sysmem_pkg::byteen_t byteenable;

	// response
	logic waitrequest;
	sysmem_pkg::data_t readdata;
	logic readdatavalid;

	modport host (
		output address,
		output burstcount,
		output read,
		output write,
		output writedata,
		output byteenable,
		input waitrequest,
		input readdata,
		input readdatavalid
	);

	modport memory (
		input address,
		input burstcount,
		input read,
		input write,
		input writedata,
		input byteenable,
		output waitrequest,
		output readdata,
		output readdatavalid
	);

endinterface

`default_nettype wire

// ==== reset_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysmem_defs.svh"

module reset_timer (
	input wire clock,
	input wire init_reset_n,
	input wire core_reset_req,
	output logic reset_out
);

	localparam sysmem_pkg::por_count_t POR_LAST = sysmem_pkg::por_count_t'(`SYSMEM_POR_CYCLES - 1);
	localparam sysmem_pkg::por_count_t POR_FULL = sysmem_pkg::por_count_t'(`SYSMEM_POR_CYCLES);

	sysmem_pkg::por_count_t por_count;
	logic por_done;

	// counter parks at the full count
	assign por_done = (por_count == POR_FULL);

	always_ff @(posedge clock or negedge init_reset_n) begin
		if (!init_reset_n) begin
			por_count <= '0;
			reset_out <= 1'b1;
		end else begin
			if (!por_done) begin
				por_count <= por_count + 1'b1;
			end
			// hand over to the core request on the last power-on edge
			if (por_count >= POR_LAST) begin
				reset_out <= core_reset_req;
			end else begin
				reset_out <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// port stays in reset until the power-on count completes
	a_por_holds_reset: assert property (@(posedge clock) disable iff (!init_reset_n)
		!por_done |-> reset_out);

endmodule

`default_nettype wire

// ==== burst_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_counter (
	input wire clock,
	input wire init_reset_n,
	input wire load,
	input wire sysmem_pkg::burst_t load_count,
	input wire beat,
	output sysmem_pkg::burst_t remaining,
	output logic last
);

	// on load the first beat may land in the same cycle
	assign last = load ? (load_count == 8'd1) : (remaining == 8'd1);

	always_ff @(posedge clock or negedge init_reset_n) begin
		if (!init_reset_n) begin
			remaining <= '0;
		end else if (load) begin
			if (beat) begin
				remaining <= load_count - 1'b1;
			end else begin
				remaining <= load_count;
			end
		end else if (beat) begin
			remaining <= remaining - 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// terminator only counts beats of a loaded burst
	a_no_extra_beat: assert property (@(posedge clock) disable iff (!init_reset_n)
		(beat && !load) |-> (remaining != '0));

endmodule

`default_nettype wire

// ==== safe_terminator_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module safe_terminator_fsm (
	input wire clock,
	input wire init_reset_n,
	input wire reset_out,

	// host side
	input wire sysmem_pkg::addr_t address,
	input wire sysmem_pkg::burst_t burstcount,
	input wire read,
	input wire write,
	input wire sysmem_pkg::data_t writedata,
	input wire sysmem_pkg::byteen_t byteenable,
	output logic waitrequest,
	output sysmem_pkg::data_t readdata,
	output logic readdatavalid,

	// memory side
	avmm_if.host mem,

	// beat tracking
	output logic load,
	output sysmem_pkg::burst_t load_count,
	output logic beat,
	input wire sysmem_pkg::burst_t remaining,
	input wire last
);

	sysmem_pkg::term_state_t state;
	sysmem_pkg::term_state_t state_next;
	logic in_pass;
	logic host_accept;

	//////////////////////////////////////////////////////////////////////
	// host to memory path
	//////////////////////////////////////////////////////////////////////

	assign in_pass = (state == sysmem_pkg::st_idle) || (state == sysmem_pkg::st_write);
	assign waitrequest = reset_out || !in_pass || mem.waitrequest;
	assign host_accept = (read || write) && !waitrequest;

	assign mem.address = address;
	assign mem.burstcount = burstcount;
	assign mem.writedata = writedata;
	// flush beats carry no enables so memory keeps its contents
	assign mem.byteenable = (state == sysmem_pkg::st_flush) ? '0 : byteenable;
	assign mem.write = (in_pass && write && !reset_out) || (state == sysmem_pkg::st_flush);
	// write wins if both are raised
	assign mem.read = (state == sysmem_pkg::st_idle) && read && !write && !reset_out;

	assign readdata = mem.readdata;
	assign readdatavalid = (state == sysmem_pkg::st_read) && mem.readdatavalid && !reset_out;

	// burst counter steering
	assign load = (state == sysmem_pkg::st_idle) && host_accept;
	assign load_count = burstcount;

	always_comb begin
		case (state)
			sysmem_pkg::st_idle,
			sysmem_pkg::st_write,
			sysmem_pkg::st_flush: beat = mem.write && !mem.waitrequest;
			sysmem_pkg::st_read,
			sysmem_pkg::st_drain: beat = mem.readdatavalid;
			default: beat = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			sysmem_pkg::st_idle: begin
				if (reset_out) begin
					state_next = sysmem_pkg::st_hold;
				end else if (load && write) begin
					// single beat writes finish right here
					if (!last) begin
						state_next = sysmem_pkg::st_write;
					end
				end else if (load) begin
					state_next = sysmem_pkg::st_read;
				end
			end
			sysmem_pkg::st_write: begin
				if (reset_out) begin
					state_next = sysmem_pkg::st_flush;
				end else if (beat && last) begin
					state_next = sysmem_pkg::st_idle;
				end
			end
			sysmem_pkg::st_read: begin
				if (beat && last) begin
					state_next = reset_out ? sysmem_pkg::st_hold : sysmem_pkg::st_idle;
				end else if (reset_out) begin
					state_next = sysmem_pkg::st_drain;
				end
			end
			sysmem_pkg::st_flush,
			sysmem_pkg::st_drain: begin
				if (beat && last) begin
					state_next = sysmem_pkg::st_hold;
				end
			end
			sysmem_pkg::st_hold: begin
				if (!reset_out) begin
					state_next = sysmem_pkg::st_idle;
				end
			end
			default: state_next = sysmem_pkg::st_hold;
		endcase
	end

	always_ff @(posedge clock or negedge init_reset_n) begin
		if (!init_reset_n) begin
			state <= sysmem_pkg::st_hold;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// host stays stalled through reset and the cycle after it ends
	a_wait_in_reset: assert property (@(posedge clock) disable iff (!init_reset_n)
		reset_out |=> waitrequest);

	// no burst is left half counted when parked
	a_parked_empty: assert property (@(posedge clock) disable iff (!init_reset_n)
		(state == sysmem_pkg::st_idle || state == sysmem_pkg::st_hold) |-> (remaining == '0));

endmodule

`default_nettype wire

// ==== burst_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysmem_defs.svh"

module burst_memory (
	input wire clock,
	input wire init_reset_n,
	avmm_if.memory bus
);

	localparam int DEPTH = 1 << `SYSMEM_ADDR_W;
	localparam int LAT = `SYSMEM_READ_LATENCY;
	localparam int BYTE_W = `SYSMEM_DATA_W / `SYSMEM_BE_W;

	sysmem_pkg::data_t mem [DEPTH];

	// write burst tracking
	sysmem_pkg::burst_t wr_left;
	sysmem_pkg::addr_t wr_addr;
	sysmem_pkg::addr_t wr_idx;
	logic wr_accept;

	// read burst tracking
	sysmem_pkg::burst_t rd_left;
	sysmem_pkg::burst_t out_left;
	sysmem_pkg::addr_t rd_addr;
	sysmem_pkg::addr_t rd_idx;
	logic rd_accept;
	logic issue;

	// read latency pipe
	sysmem_pkg::data_t pipe_data [LAT];
	logic [LAT-1:0] pipe_valid;

	assign wr_accept = bus.write && !bus.waitrequest;
	// first beat takes the bus address
	assign wr_idx = (wr_left == '0) ? bus.address : wr_addr;

	assign rd_accept = bus.read && !bus.waitrequest;
	assign issue = rd_accept || (rd_left != '0);
	assign rd_idx = rd_accept ? bus.address : rd_addr;

	// busy until every read beat has left the pipe
	assign bus.waitrequest = (out_left != '0);
	assign bus.readdata = pipe_data[LAT-1];
	assign bus.readdatavalid = pipe_valid[LAT-1];

	always_ff @(posedge clock or negedge init_reset_n) begin
		if (!init_reset_n) begin
			wr_left <= '0;
			wr_addr <= '0;
		end else if (wr_accept) begin
			wr_left <= (wr_left == '0) ? bus.burstcount - 1'b1 : wr_left - 1'b1;
			wr_addr <= wr_idx + 1'b1;
		end
	end

	always_ff @(posedge clock or negedge init_reset_n) begin
		if (!init_reset_n) begin
			rd_left <= '0;
			rd_addr <= '0;
			out_left <= '0;
			pipe_valid <= '0;
		end else begin
			if (issue) begin
				rd_left <= (rd_accept ? bus.burstcount : rd_left) - 1'b1;
				rd_addr <= rd_idx + 1'b1;
			end
			if (rd_accept) begin
				out_left <= bus.burstcount;
			end else if (bus.readdatavalid) begin
				out_left <= out_left - 1'b1;
			end
			pipe_valid[0] <= issue;
			for (int i = 1; i < LAT; i++) begin
				pipe_valid[i] <= pipe_valid[i-1];
			end
		end
	end

	// storage and read data pipe
	always_ff @(posedge clock) begin
		if (wr_accept) begin
			for (int b = 0; b < `SYSMEM_BE_W; b++) begin
				if (bus.byteenable[b]) begin
					mem[wr_idx][b*BYTE_W +: BYTE_W] <= bus.writedata[b*BYTE_W +: BYTE_W];
				end
			end
		end
		pipe_data[0] <= mem[rd_idx];
		for (int i = 1; i < LAT; i++) begin
			pipe_data[i] <= pipe_data[i-1];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// terminator drives one command kind at a time
	a_no_read_write: assert property (@(posedge clock) disable iff (!init_reset_n)
		!(bus.read && bus.write));

endmodule

`default_nettype wire

// ==== sysmem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sysmem_top (
	input wire clock,
	input wire init_reset_n,
	input wire core_reset_req,
	output logic reset_out,

	// host avalon port
	input wire sysmem_pkg::addr_t address,
	input wire sysmem_pkg::burst_t burstcount,
	input wire read,
	input wire write,
	input wire sysmem_pkg::data_t writedata,
	input wire sysmem_pkg::byteen_t byteenable,
	output logic waitrequest,
	output sysmem_pkg::data_t readdata,
	output logic readdatavalid
);

	// terminator to beat counter
	logic load;
	sysmem_pkg::burst_t load_count;
	logic beat;
	sysmem_pkg::burst_t remaining;
	logic last;

	avmm_if mem_bus ();

	reset_timer u_reset_timer (
		.clock          (clock),
		.init_reset_n   (init_reset_n),
		.core_reset_req (core_reset_req),
		.reset_out      (reset_out)
	);

	burst_counter u_burst_counter (
		.clock        (clock),
		.init_reset_n (init_reset_n),
		.load         (load),
		.load_count   (load_count),
		.beat         (beat),
		.remaining    (remaining),
		.last         (last)
	);

	safe_terminator_fsm u_terminator (
		.clock         (clock),
		.init_reset_n  (init_reset_n),
		.reset_out     (reset_out),
		.address       (address),
		.burstcount    (burstcount),
		.read          (read),
		.write         (write),
		.writedata     (writedata),
		.byteenable    (byteenable),
		.waitrequest   (waitrequest),
		.readdata      (readdata),
		.readdatavalid (readdatavalid),
		.mem           (mem_bus.host),
		.load          (load),
		.load_count    (load_count),
		.beat          (beat),
		.remaining     (remaining),
		.last          (last)
	);

	burst_memory u_memory (
		.clock        (clock),
		.init_reset_n (init_reset_n),
		.bus          (mem_bus.memory)
	);

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clock
);

	// free running, first rising edge half a period in
	initial begin
		clock = 1'b0;
		forever begin
			#(PERIOD_NS / 2.0) clock = ~clock;
		end
	end

endmodule

`default_nettype wire

// ==== sysmem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysmem_defs.svh"

module sysmem_tb;

	localparam int NUM_TESTS = 12;
	localparam int LAT = `SYSMEM_READ_LATENCY;
	localparam int POR = `SYSMEM_POR_CYCLES;
	localparam int WATCHDOG_NS = NUM_TESTS * (255 + LAT + 40) * 4;
	localparam logic [7:0] NO_RESET = 8'hff;
	localparam int RESET_HOLD = 3;

	typedef struct packed {
		logic is_write;
		logic [`SYSMEM_ADDR_W-1:0] addr;
		logic [`SYSMEM_BURST_W-1:0] count;
		logic [`SYSMEM_BE_W-1:0] be;
		logic [7:0] reset_beat;
	} test_t;

	logic clock;
	logic init_reset_n;
	logic core_reset_req;
	logic reset_out;
	sysmem_pkg::addr_t address;
	sysmem_pkg::burst_t burstcount;
	logic read;
	logic write;
	sysmem_pkg::data_t writedata;
	sysmem_pkg::byteen_t byteenable;
	logic waitrequest;
	sysmem_pkg::data_t readdata;
	logic readdatavalid;

	integer seed;
	int error_count;
	int failed_tests;
	test_t tests [NUM_TESTS];
	logic [`SYSMEM_DATA_W-1:0] model_mem [1 << `SYSMEM_ADDR_W];

	tb_clock_gen #(.PERIOD_NS(4.0)) u_clock_gen (.clock(clock));

	sysmem_top u_dut (
		.clock          (clock),
		.init_reset_n   (init_reset_n),
		.core_reset_req (core_reset_req),
		.reset_out      (reset_out),
		.address        (address),
		.burstcount     (burstcount),
		.read           (read),
		.write          (write),
		.writedata      (writedata),
		.byteenable     (byteenable),
		.waitrequest    (waitrequest),
		.readdata       (readdata),
		.readdatavalid  (readdatavalid)
	);

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic compare_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	// byte lane merge as seen by a byte-enabled memory
	function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
			input logic [63:0] new_word, input logic [7:0] be);
		logic [63:0] result;
		result = old_word;
		for (int b = 0; b < 8; b++) begin
			if (be[b]) begin
				result[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return result;
	endfunction

	task automatic load_table();
		// op, address, burstcount, byte enables, beat that raises core reset
		tests[0] = '{1'b1, 8'h10, 8'd4, 8'hff, NO_RESET};
		tests[1] = '{1'b0, 8'h10, 8'd4, 8'hff, NO_RESET};
		tests[2] = '{1'b1, 8'h12, 8'd2, 8'h5a, NO_RESET};
		tests[3] = '{1'b0, 8'h10, 8'd4, 8'hff, NO_RESET};
		tests[4] = '{1'b1, 8'h40, 8'd8, 8'hff, NO_RESET};
		tests[5] = '{1'b1, 8'h40, 8'd8, 8'hff, 8'd3};
		tests[6] = '{1'b0, 8'h40, 8'd8, 8'hff, NO_RESET};
		tests[7] = '{1'b1, 8'h80, 8'd6, 8'hff, NO_RESET};
		tests[8] = '{1'b0, 8'h80, 8'd6, 8'hff, 8'd2};
		tests[9] = '{1'b0, 8'h80, 8'd6, 8'hff, NO_RESET};
		// burst that wraps the top of memory
		tests[10] = '{1'b1, 8'hfe, 8'd4, 8'hff, NO_RESET};
		tests[11] = '{1'b0, 8'hfe, 8'd4, 8'hff, NO_RESET};
	endtask

	task automatic power_on_check();
		repeat (2) begin
			next_cycle();
			compare_value("reset_out", 1, reset_out);
		end
		init_reset_n = 1'b1;
		for (int edges = 1; edges <= POR + 1; edges++) begin
			next_cycle();
			if (edges <= POR - 1) begin
				compare_value("reset_out", 1, reset_out);
				compare_value("waitrequest", 1, waitrequest);
				compare_value("readdatavalid", 0, readdatavalid);
			end
		end
		compare_value("reset_out", 0, reset_out);
		while (waitrequest) begin
			next_cycle();
		end
	endtask

	// hold the core request a few cycles, then wait for the port to return
	task automatic ride_out_reset();
		int held;
		logic seen_high;
		held = 0;
		seen_high = 1'b0;
		while (held < RESET_HOLD || waitrequest) begin
			@(negedge clock);
			if (reset_out) begin
				seen_high = 1'b1;
				compare_value("waitrequest", 1, waitrequest);
			end
			compare_value("readdatavalid", 0, readdatavalid);
			next_cycle();
			held++;
			if (held == RESET_HOLD) begin
				core_reset_req = 1'b0;
			end
		end
		compare_value("reset_out rise seen", 1, seen_high);
	endtask

	task automatic run_write(input test_t t);
		int beat_idx;
		logic accepted;
		logic cut_off;
		sysmem_pkg::addr_t idx;
		beat_idx = 0;
		cut_off = 1'b0;
		while (beat_idx < t.count && !cut_off) begin
			if (beat_idx == t.reset_beat) begin
				core_reset_req = 1'b1;
			end
			write = 1'b1;
			address = t.addr;
			burstcount = t.count;
			writedata = {$random(seed), $random(seed)};
			byteenable = t.be;
			accepted = 1'b0;
			while (!accepted && !cut_off) begin
				@(negedge clock);
				if (reset_out) begin
					cut_off = 1'b1;
				end else if (!waitrequest) begin
					accepted = 1'b1;
					idx = t.addr + beat_idx[7:0];
					model_mem[idx] = merge_bytes(model_mem[idx], writedata, t.be);
				end
				next_cycle();
			end
			if (accepted) begin
				beat_idx++;
			end
		end
		write = 1'b0;
		byteenable = '0;
		if (core_reset_req) begin
			ride_out_reset();
		end
	endtask

	task automatic run_read(input test_t t);
		int beats;
		logic accepted;
		logic raised;
		logic cut_off;
		logic done;
		sysmem_pkg::addr_t idx;
		beats = 0;
		accepted = 1'b0;
		raised = 1'b0;
		cut_off = 1'b0;
		done = 1'b0;
		read = 1'b1;
		address = t.addr;
		burstcount = t.count;
		while (!accepted) begin
			@(negedge clock);
			accepted = !waitrequest;
			next_cycle();
		end
		read = 1'b0;
		// count beats until the port stops stalling
		while (!done && !cut_off) begin
			if (beats == t.reset_beat && !raised) begin
				core_reset_req = 1'b1;
				raised = 1'b1;
			end
			@(negedge clock);
			if (reset_out) begin
				cut_off = 1'b1;
				compare_value("readdatavalid", 0, readdatavalid);
			end else begin
				if (readdatavalid) begin
					idx = t.addr + beats[7:0];
					compare_value("readdata", model_mem[idx], readdata);
					beats++;
				end
				if (!waitrequest) begin
					done = 1'b1;
				end
			end
			next_cycle();
		end
		if (raised) begin
			ride_out_reset();
		end else begin
			compare_value("readdatavalid beats", t.count, beats);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int errors_before;
		seed = 56085;
		init_reset_n = 1'b0;
		core_reset_req = 1'b0;
		address = '0;
		burstcount = '0;
		read = 1'b0;
		write = 1'b0;
		writedata = '0;
		byteenable = '0;
		error_count = 0;
		failed_tests = 0;
		load_table();
		for (int a = 0; a < (1 << `SYSMEM_ADDR_W); a++) begin
			model_mem[a] = '0;
		end

		power_on_check();
		$display("power-on reset: %s", (error_count == 0) ? "ok" : "failed");
		if (error_count != 0) begin
			failed_tests++;
		end

		for (int i = 0; i < NUM_TESTS; i++) begin
			errors_before = error_count;
			if (tests[i].is_write) begin
				run_write(tests[i]);
			end else begin
				run_read(tests[i]);
			end
			if (error_count != errors_before) begin
				failed_tests++;
			end
			$display("test %0d %s addr %h count %0d: %s", i,
				tests[i].is_write ? "write" : "read", tests[i].addr, tests[i].count,
				(error_count == errors_before) ? "ok" : "failed");
		end

		$display("%0d tests run, %0d failed, %0d errors", NUM_TESTS + 1, failed_tests,
			error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// hard stop if a handshake never completes
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, a handshake never completed", WATCHDOG_NS);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
sysmem_pkg.sv
avmm_if.sv
reset_timer.sv
burst_counter.sv
safe_terminator_fsm.sv
burst_memory.sv
sysmem_top.sv
tb_clock_gen.sv
sysmem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f \
	--top-module sysmem_tb \
	--Mdir obj_dir \
	-o sysmem_sim

output=$(./obj_dir/sysmem_sim)
echo "$output"

echo "$output" | grep -qx "TEST PASS"
